// File: cameraGrabber.f
+incdir+logic
logic/camGrabberPkg.sv
logic/grabberIfs.sv
logic/syncTimer.sv
logic/grayPacker.sv
logic/lineBuffer.sv
logic/ciRegisters.sv
logic/dmaMaster.sv
logic/cameraGrabber.sv
verification/clockGen.sv
verification/grabber_sva.sv
verification/grabberTb.sv

// File: logic/camGrabberPkg.sv
package camGrabberPkg;

  // instruction selector, taken from ciValueA[3:0]
  // opcodes 2 and 3 are unused and read zero
  typedef enum logic [3:0] {
    OpBytesPerLine  = 4'd0,
    OpLinesPerFrame = 4'd1,
    OpReadBase      = 4'd4,
    OpWriteBase     = 4'd5,
    OpControl       = 4'd6,
    OpShotDone      = 4'd7
  } ciOpcode;

  // bus master states
  typedef enum logic [2:0] {
    Idle      = 3'd0,
    Request   = 3'd1,
    InitBurst = 3'd2,
    DoBurst   = 3'd3,
    EndBurst  = 3'd4,
    ErrorEnd  = 3'd5
  } dmaState;

endpackage

// File: logic/camGrabber_settings.svh
`ifndef CAM_GRABBER_SETTINGS_SVH
`define CAM_GRABBER_SETTINGS_SVH

// custom instruction number this grabber answers
`define CI_ID 8'd0

// byte and line counter width
`define COUNT_W 11

// bus and data word width
`define WORD_W 32

// line buffer address width, 256 words
`define BUF_AW 8

// longest burst in words
`define MAX_BURST 16

// gray pixel width
`define GRAY_W 8

`endif

// File: logic/cameraGrabber.sv
`timescale 1ns/1ps
`include "camGrabber_settings.svh"

module cameraGrabber (
  input  logic        pclk,
  input  logic        rstN,
  input  logic [7:0]  camData,
  input  logic        hsync,
  input  logic        vsync,
  input  logic        ciStart,
  input  logic [7:0]  ciN,
  input  logic [31:0] ciValueA,
  input  logic [31:0] ciValueB,
  output logic [31:0] ciResult,
  output logic        ciDone,
  output logic        requestBus,
  input  logic        busGrant,
  output logic        beginTransactionOut,
  output logic [31:0] addressDataOut,
  output logic        endTransactionOut,
  output logic [3:0]  byteEnablesOut,
  output logic        dataValidOut,
  output logic [7:0]  burstSizeOut,
  input  logic        busyIn,
  input  logic        busErrorIn
);

  logic               wrEn;
  logic [`BUF_AW-1:0] wrAddr;
  logic [`WORD_W-1:0] wrData;
  logic [`BUF_AW-1:0] rdAddr;
  logic [`WORD_W-1:0] rdData;

  syncStatusIf statusBus ();
  grabCtrlIf   ctrlBus ();

  syncTimer timer (
    .pclk   (pclk),
    .rstN   (rstN),
    .hsync  (hsync),
    .vsync  (vsync),
    .status (statusBus.timer)
  );

  grayPacker packer (
    .pclk    (pclk),
    .rstN    (rstN),
    .camData (camData),
    .hsync   (hsync),
    .status  (statusBus.packer),
    .wrEn    (wrEn),
    .wrAddr  (wrAddr),
    .wrData  (wrData)
  );

  lineBuffer lineBuf (
    .pclk   (pclk),
    .wrEn   (wrEn),
    .wrAddr (wrAddr),
    .wrData (wrData),
    .rdAddr (rdAddr),
    .rdData (rdData)
  );

  ciRegisters regs (
    .pclk     (pclk),
    .rstN     (rstN),
    .ciStart  (ciStart),
    .ciN      (ciN),
    .ciValueA (ciValueA),
    .ciValueB (ciValueB),
    .ciResult (ciResult),
    .ciDone   (ciDone),
    .status   (statusBus.regs),
    .ctrl     (ctrlBus.regs)
  );

  dmaMaster dma (
    .pclk                (pclk),
    .rstN                (rstN),
    .requestBus          (requestBus),
    .busGrant            (busGrant),
    .beginTransactionOut (beginTransactionOut),
    .addressDataOut      (addressDataOut),
    .endTransactionOut   (endTransactionOut),
    .byteEnablesOut      (byteEnablesOut),
    .dataValidOut        (dataValidOut),
    .burstSizeOut        (burstSizeOut),
    .busyIn              (busyIn),
    .busErrorIn          (busErrorIn),
    .rdAddr              (rdAddr),
    .rdData              (rdData),
    .status              (statusBus.dma),
    .ctrl                (ctrlBus.dma)
  );

endmodule

// File: logic/ciRegisters.sv
`timescale 1ns/1ps
`include "camGrabber_settings.svh"

module ciRegisters import camGrabberPkg::*; (
  input  logic        pclk,
  input  logic        rstN,
  input  logic        ciStart,
  input  logic [7:0]  ciN,
  input  logic [31:0] ciValueA,
  input  logic [31:0] ciValueB,
  output logic [31:0] ciResult,
  output logic        ciDone,
  syncStatusIf.regs   status,
  grabCtrlIf.regs     ctrl
);

  ciOpcode     opcode;
  logic        isMyCi;
  logic        writeBase;
  logic        writeControl;
  logic        shotCmd;
  logic        shotDoneFlag;
  logic [31:0] selected;

  assign opcode       = ciOpcode'(ciValueA[3:0]);
  assign isMyCi       = ciStart && (ciN == `CI_ID);
  assign writeBase    = isMyCi && (opcode == OpWriteBase);
  assign writeControl = isMyCi && (opcode == OpControl);
  assign shotCmd      = writeControl && (ciValueB[1:0] == 2'b10);

  assign ciDone   = isMyCi;
  assign ciResult = isMyCi ? selected : 32'd0;

  always_comb begin
    case (opcode)
      OpBytesPerLine:  selected = {{(32-`COUNT_W){1'b0}}, status.bytesPerLine};
      OpLinesPerFrame: selected = {{(32-`COUNT_W){1'b0}}, status.linesPerFrame};
      OpReadBase:      selected = ctrl.frameBase;
      OpShotDone:      selected = {31'd0, shotDoneFlag};
      default:         selected = 32'd0;
    endcase
  end

  always_ff @(posedge pclk) begin
    if (!rstN) begin
      ctrl.frameBase     <= '0;
      ctrl.runContinuous <= 1'b0;
      ctrl.shotRequest   <= 1'b0;
      shotDoneFlag       <= 1'b0;
    end else begin
      // base stays word aligned
      if (writeBase) begin
        ctrl.frameBase <= {ciValueB[31:2], 2'b00};
      end
      if (writeControl) begin
        ctrl.runContinuous <= (ciValueB[1:0] == 2'b01);
      end
      // request is held until the bus master takes it at a frame start
      if (shotCmd) begin
        ctrl.shotRequest <= 1'b1;
      end else if (ctrl.shotTaken) begin
        ctrl.shotRequest <= 1'b0;
      end
      if (shotCmd) begin
        shotDoneFlag <= 1'b0;
      end else if (ctrl.shotDone) begin
        shotDoneFlag <= 1'b1;
      end
    end
  end

endmodule

// File: logic/dmaMaster.sv
`timescale 1ns/1ps
`include "camGrabber_settings.svh"

module dmaMaster import camGrabberPkg::*; (
  input  logic               pclk,
  input  logic               rstN,
  output logic               requestBus,
  input  logic               busGrant,
  output logic               beginTransactionOut,
  output logic [`WORD_W-1:0] addressDataOut,
  output logic               endTransactionOut,
  output logic [3:0]         byteEnablesOut,
  output logic               dataValidOut,
  output logic [7:0]         burstSizeOut,
  input  logic               busyIn,
  input  logic               busErrorIn,
  output logic [`BUF_AW-1:0] rdAddr,
  input  logic [`WORD_W-1:0] rdData,
  syncStatusIf.dma           status,
  grabCtrlIf.dma             ctrl
);

  localparam logic [`BUF_AW-1:0] maxBurst = `MAX_BURST;

  dmaState            state;
  dmaState            stateNext;
  logic               grabRunning;
  logic               shotActive;
  logic               startLine;
  logic               inBurst;
  logic               holdBus;
  logic               sendWord;
  logic               burstEnd;
  logic [`BUF_AW-1:0] lineWords;
  logic [`BUF_AW-1:0] wordsLeft;
  logic [`BUF_AW-1:0] burstLen;
  logic [`BUF_AW-1:0] burstCount;
  logic [`BUF_AW-1:0] wordPtr;
  logic [`WORD_W-1:0] busAddress;

  // four gray pixels per word, two bytes per pixel
  assign lineWords = status.bytesPerLine[`COUNT_W-1:3];
  assign burstLen  = (wordsLeft > maxBurst) ? maxBurst : wordsLeft;

  assign startLine = (state == Idle) && status.lineDone && (grabRunning || shotActive) &&
                     (lineWords != '0);
  assign inBurst   = (state == DoBurst) && !busErrorIn;
  assign holdBus   = inBurst && busyIn;
  assign sendWord  = inBurst && !busyIn && (burstCount != '0);
  assign burstEnd  = inBurst && !busyIn && (burstCount == '0);

  assign requestBus = (state == Request);

  // read ahead so rdData always holds the word at wordPtr
  assign rdAddr = startLine ? '0 : (sendWord ? wordPtr + 1'b1 : wordPtr);

  always_comb begin
    stateNext = state;
    case (state)
      Idle:      if (startLine) stateNext = Request;
      Request:   if (busGrant) stateNext = InitBurst;
      InitBurst: stateNext = DoBurst;
      DoBurst: begin
        if (busErrorIn) begin
          stateNext = ErrorEnd;
        end else if (burstEnd) begin
          stateNext = EndBurst;
        end
      end
      EndBurst:  stateNext = (wordsLeft != '0) ? Request : Idle;
      ErrorEnd:  stateNext = Idle;
      default:   stateNext = Idle;
    endcase
  end

  always_ff @(posedge pclk) begin
    if (!rstN) begin
      state               <= Idle;
      grabRunning         <= 1'b0;
      shotActive          <= 1'b0;
      ctrl.shotTaken      <= 1'b0;
      ctrl.shotDone       <= 1'b0;
      wordsLeft           <= '0;
      burstCount          <= '0;
      wordPtr             <= '0;
      busAddress          <= '0;
      beginTransactionOut <= 1'b0;
      endTransactionOut   <= 1'b0;
      byteEnablesOut      <= 4'h0;
      dataValidOut        <= 1'b0;
      burstSizeOut        <= 8'd0;
    end else begin
      state          <= stateNext;
      wordPtr        <= rdAddr;
      ctrl.shotTaken <= status.frameStart && ctrl.shotRequest;
      // a shot taken at one frame start ends at the next
      ctrl.shotDone  <= status.frameStart && shotActive;

      if (status.frameStart) begin
        grabRunning <= ctrl.runContinuous;
        shotActive  <= ctrl.shotRequest;
        busAddress  <= ctrl.frameBase;
      end else if (sendWord) begin
        busAddress <= busAddress + 32'd4;
      end

      if (startLine) begin
        wordsLeft <= lineWords;
      end else if (state == InitBurst) begin
        wordsLeft <= wordsLeft - burstLen;
      end

      if (state == InitBurst) begin
        burstCount <= burstLen;
      end else if (sendWord) begin
        burstCount <= burstCount - 1'b1;
      end

      // everything on the bus freezes while the slave is busy
      if (!holdBus) begin
        beginTransactionOut <= (state == InitBurst);
        byteEnablesOut      <= (state == InitBurst) ? 4'hF : 4'h0;
        burstSizeOut        <= (state == InitBurst) ? burstLen - 1'b1 : 8'd0;
        dataValidOut        <= sendWord;
        endTransactionOut   <= burstEnd || ((state == DoBurst) && busErrorIn);
      end
    end
  end

  // address on the begin cycle, then the line words
  always_ff @(posedge pclk) begin
    if (state == InitBurst) begin
      addressDataOut <= busAddress;
    end else if (sendWord) begin
      addressDataOut <= rdData;
    end else if (!holdBus) begin
      addressDataOut <= '0;
    end
  end

endmodule

// File: logic/grabberIfs.sv
`timescale 1ns/1ps
`include "camGrabber_settings.svh"

// line and frame timing, driven only by the sync timer
interface syncStatusIf;
  logic                lineDone;
  logic                frameStart;
  logic [`COUNT_W-1:0] byteIndex;
  logic [`COUNT_W-1:0] bytesPerLine;
  logic [`COUNT_W-1:0] linesPerFrame;

  modport timer (
    output lineDone,
    output frameStart,
    output byteIndex,
    output bytesPerLine,
    output linesPerFrame
  );

  modport packer (
    input byteIndex
  );

  modport regs (
    input bytesPerLine,
    input linesPerFrame
  );

  modport dma (
    input lineDone,
    input frameStart,
    input bytesPerLine
  );
endinterface

// grab control between the register block and the bus master
interface grabCtrlIf;
  logic [`WORD_W-1:0] frameBase;
  logic               runContinuous;
  logic               shotRequest;
  // one-cycle strobes from the bus master
  logic               shotDone;
  logic               shotTaken;

  modport regs (
    output frameBase,
    output runContinuous,
    output shotRequest,
    input  shotDone,
    input  shotTaken
  );

  modport dma (
    input  frameBase,
    input  runContinuous,
    input  shotRequest,
    output shotDone,
    output shotTaken
  );
endinterface

// File: logic/grayPacker.sv
`timescale 1ns/1ps
`include "camGrabber_settings.svh"

module grayPacker (
  input  logic                pclk,
  input  logic                rstN,
  input  logic [7:0]          camData,
  input  logic                hsync,
  syncStatusIf.packer         status,
  output logic                wrEn,
  output logic [`BUF_AW-1:0]  wrAddr,
  output logic [`WORD_W-1:0]  wrData
);

  logic [7:0]         byteReg [0:6];
  logic [2:0]         slot;
  logic               lastByte;
  logic [`GRAY_W-1:0] gray0;
  logic [`GRAY_W-1:0] gray1;
  logic [`GRAY_W-1:0] gray2;
  logic [`GRAY_W-1:0] gray3;

  // rgb565 pixel, high byte first, weighted 2:5:1 on the 8-bit scaled fields
  function automatic logic [`GRAY_W-1:0] toGray(input logic [7:0] hiByte,
                                                input logic [7:0] loByte);
    logic [11:0] redPart;
    logic [11:0] greenPart;
    logic [11:0] bluePart;
    logic [11:0] sum;
    redPart   = {4'd0, hiByte[7:3], 3'b000} * 12'd2;
    greenPart = {4'd0, hiByte[2:0], loByte[7:5], 2'b00} * 12'd5;
    bluePart  = {4'd0, loByte[4:0], 3'b000};
    sum       = redPart + greenPart + bluePart;
    return sum[`GRAY_W+2:3];
  endfunction

  assign slot     = status.byteIndex[2:0];
  assign lastByte = hsync && (slot == 3'd7);

  // the 8th byte of a group is used directly from camData
  assign gray0 = toGray(byteReg[0], byteReg[1]);
  assign gray1 = toGray(byteReg[2], byteReg[3]);
  assign gray2 = toGray(byteReg[4], byteReg[5]);
  assign gray3 = toGray(byteReg[6], camData);

  always_ff @(posedge pclk) begin
    if (hsync && !lastByte) begin
      byteReg[slot] <= camData;
    end
  end

  always_ff @(posedge pclk) begin
    if (!rstN) begin
      wrEn <= 1'b0;
    end else begin
      wrEn <= lastByte;
    end
  end

  // word is captured with the 8th byte, first pixel in the top byte
  always_ff @(posedge pclk) begin
    if (lastByte) begin
      wrAddr <= status.byteIndex[`BUF_AW+2:3];
      wrData <= {gray0, gray1, gray2, gray3};
    end
  end

endmodule

// File: logic/lineBuffer.sv
`timescale 1ns/1ps
`include "camGrabber_settings.svh"

module lineBuffer (
  input  logic               pclk,
  input  logic               wrEn,
  input  logic [`BUF_AW-1:0] wrAddr,
  input  logic [`WORD_W-1:0] wrData,
  input  logic [`BUF_AW-1:0] rdAddr,
  output logic [`WORD_W-1:0] rdData
);

  localparam int bufDepth = 2 ** `BUF_AW;

  // one line of packed gray words
  logic [`WORD_W-1:0] mem [0:bufDepth-1];

  always_ff @(posedge pclk) begin
    if (wrEn) begin
      mem[wrAddr] <= wrData;
    end
  end

  // registered read, data one cycle after the address
  always_ff @(posedge pclk) begin
    rdData <= mem[rdAddr];
  end

endmodule

// File: logic/syncTimer.sv
`timescale 1ns/1ps
`include "camGrabber_settings.svh"

module syncTimer (
  input  logic       pclk,
  input  logic       rstN,
  input  logic       hsync,
  input  logic       vsync,
  syncStatusIf.timer status
);

  logic                hsyncQ;
  logic                vsyncQ;
  logic                hsyncFall;
  logic                vsyncFall;
  logic [`COUNT_W-1:0] byteCount;
  logic [`COUNT_W-1:0] lineCount;

  // falling edges seen on the current sample
  assign hsyncFall = hsyncQ & ~hsync;
  assign vsyncFall = vsyncQ & ~vsync;

  // index of the byte taken on this cycle
  assign status.byteIndex = byteCount;

  always_ff @(posedge pclk) begin
    if (!rstN) begin
      hsyncQ               <= 1'b0;
      vsyncQ               <= 1'b0;
      byteCount            <= '0;
      lineCount            <= '0;
      status.lineDone      <= 1'b0;
      status.frameStart    <= 1'b0;
      status.bytesPerLine  <= '0;
      status.linesPerFrame <= '0;
    end else begin
      hsyncQ            <= hsync;
      vsyncQ            <= vsync;
      status.lineDone   <= hsyncFall;
      status.frameStart <= vsyncFall;

      // bytes are counted only while hsync is high
      if (hsyncFall) begin
        status.bytesPerLine <= byteCount;
        byteCount           <= '0;
      end else if (hsync) begin
        byteCount <= byteCount + 1'b1;
      end

      // a frame end restarts the line count
      if (vsyncFall) begin
        status.linesPerFrame <= lineCount;
        lineCount            <= '0;
      end else if (hsyncFall) begin
        lineCount <= lineCount + 1'b1;
      end
    end
  end

endmodule

// File: runSim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module grabberTb -f cameraGrabber.f
output=$(./obj_dir/VgrabberTb)
echo "$output"
echo "$output" | grep -q "RESULT: PASS"

// File: verification/clockGen.sv
`timescale 1ns/1ps

module clockGen (
  output logic pclk,
  output logic rstN
);

  // 20 ns period
  initial begin
    pclk = 1'b0;
    forever #10 pclk = ~pclk;
  end

  // reset held for 10 cycles, released on a falling edge
  initial begin
    rstN = 1'b0;
    repeat (10) @(posedge pclk);
    @(negedge pclk);
    rstN = 1'b1;
  end

endmodule

// File: verification/grabberTb.sv
`timescale 1ns/1ps

module grabberTb;

  localparam int lineBytes   = 96;
  localparam int frameLines  = 4;
  localparam int hBlank      = 60;
  localparam int frameCycles = 10 + 20 + frameLines * (lineBytes + hBlank) + 60;
  // four frames plus the closing sync pulse
  localparam int framesSent  = 5;
  localparam logic [31:0] baseAddr = 32'h0000_1000;
  // sixth word of the second line of the second frame
  localparam int errWordIdx  = 65;

  logic        pclk;
  logic        rstN;
  logic [7:0]  camData = 8'd0;
  logic        hsync = 1'b0;
  logic        vsync = 1'b0;
  logic        ciStart = 1'b0;
  logic [7:0]  ciN = 8'd0;
  logic [31:0] ciValueA = 32'd0;
  logic [31:0] ciValueB = 32'd0;
  logic [31:0] ciResult;
  logic        ciDone;
  logic        requestBus;
  logic        busGrant = 1'b0;
  logic        beginTransactionOut;
  logic [31:0] addressDataOut;
  logic        endTransactionOut;
  logic [3:0]  byteEnablesOut;
  logic        dataValidOut;
  logic [7:0]  burstSizeOut;
  logic        busyIn = 1'b0;
  logic        busErrorIn = 1'b0;

  integer      seed = 32'h415c;
  int          errors = 0;
  int          wordsChecked = 0;
  int          lineId = 0;
  int          lastLine = 0;
  int          frameWritten = 0;
  int          expectBurst = 0;
  int          gotBurst = 0;
  int          grantWait = 0;
  int          busyRun = 0;
  bit          burstOpen = 1'b0;
  bit          errUsed = 1'b0;
  bit          errInBurst = 1'b0;
  bit          held;
  logic        prevRequest = 1'b0;
  logic [31:0] prevAddr;
  logic [7:0]  prevSize;
  logic [3:0]  prevBe;
  logic        prevBegin;
  logic        prevValid;
  logic        prevEnd;
  logic [31:0] expWords [$];
  int          expLines [$];
  logic [31:0] readValue;

  clockGen clocks (
    .pclk (pclk),
    .rstN (rstN)
  );

  cameraGrabber dut (.*);

  bind cameraGrabber grabber_sva sva (
    .pclk                (pclk),
    .rstN                (rstN),
    .ciDone              (ciDone),
    .ciResult            (ciResult),
    .beginTransactionOut (beginTransactionOut),
    .endTransactionOut   (endTransactionOut),
    .dataValidOut        (dataValidOut),
    .byteEnablesOut      (byteEnablesOut),
    .burstSizeOut        (burstSizeOut),
    .addressDataOut      (addressDataOut),
    .busyIn              (busyIn),
    .busErrorIn          (busErrorIn),
    .lineDone            (statusBus.lineDone)
  );

  // 2:5:1 weights on the 8-bit scaled red, green and blue fields
  function automatic logic [7:0] grayOf(input logic [7:0] hi, input logic [7:0] lo);
    int red;
    int green;
    int blue;
    red   = hi[7:3];
    green = {hi[2:0], lo[7:5]};
    blue  = lo[4:0];
    return 8'((red * 8 * 2 + green * 4 * 5 + blue * 8) / 8);
  endfunction

  task automatic vsyncPulse();
    repeat (10) begin
      @(negedge pclk);
      vsync = 1'b1;
    end
    @(negedge pclk);
    vsync = 1'b0;
    frameWritten = 0;
  endtask

  task automatic sendFrame(input bit captured);
    logic [7:0] bytes [0:7];
    vsyncPulse();
    repeat (20) @(negedge pclk);
    for (int line = 0; line < frameLines; line++) begin
      for (int b = 0; b < lineBytes; b++) begin
        @(negedge pclk);
        hsync   = 1'b1;
        camData = 8'($random(seed));
        bytes[b % 8] = camData;
        if ((b % 8 == 7) && captured) begin
          expWords.push_back({grayOf(bytes[0], bytes[1]), grayOf(bytes[2], bytes[3]),
                              grayOf(bytes[4], bytes[5]), grayOf(bytes[6], bytes[7])});
          expLines.push_back(lineId);
        end
      end
      @(negedge pclk);
      hsync   = 1'b0;
      camData = 8'd0;
      lineId++;
      repeat (hBlank - 1) @(negedge pclk);
    end
    repeat (60) @(negedge pclk);
  endtask

  task automatic ciAccess(input logic [3:0] op, input logic [31:0] valB,
                          output logic [31:0] result);
    @(negedge pclk);
    ciStart  = 1'b1;
    ciN      = 8'd0;
    ciValueA = {28'd0, op};
    ciValueB = valB;
    #5;
    result = ciResult;
    assert (ciDone) else begin
      errors++;
      $display("No ciDone for opcode %0d", op);
    end
    @(negedge pclk);
    ciStart  = 1'b0;
    ciValueA = 32'd0;
    ciValueB = 32'd0;
  endtask

  // an access for another instruction number leaves done and result low
  task automatic otherCiAccess(input logic [7:0] otherId);
    @(negedge pclk);
    ciStart  = 1'b1;
    ciN      = otherId;
    ciValueA = 32'd0;
    #5;
    assert (!ciDone && ciResult == 32'd0) else begin
      errors++;
      $display("Mismatch at %0t: instruction %0d answered with %0h", $time, otherId,
               ciResult);
    end
    @(negedge pclk);
    ciStart = 1'b0;
    ciN     = 8'd0;
  endtask

  task automatic checkRead(input logic [3:0] op, input logic [31:0] expected);
    logic [31:0] got;
    ciAccess(op, 32'd0, got);
    assert (got == expected) else begin
      errors++;
      $display("Mismatch at %0t: opcode %0d read %0h, expected %0h", $time, op, got, expected);
    end
  endtask

  // bus monitor and memory model share one process, outputs first
  always @(negedge pclk) begin
    if (rstN) begin
      held = burstOpen && busyIn && !busErrorIn;
      if (held) begin
        assert (addressDataOut == prevAddr && dataValidOut == prevValid &&
                beginTransactionOut == prevBegin && endTransactionOut == prevEnd &&
                burstSizeOut == prevSize && byteEnablesOut == prevBe) else begin
          errors++;
          $display("Mismatch at %0t: bus outputs moved while busyIn was high", $time);
        end
      end else begin
        if (beginTransactionOut) begin
          assert (addressDataOut == baseAddr + 32'(4 * frameWritten)) else begin
            errors++;
            $display("Mismatch at %0t: burst address %0h, expected %0h", $time,
                     addressDataOut, baseAddr + 32'(4 * frameWritten));
          end
          burstOpen   = 1'b1;
          expectBurst = int'(burstSizeOut) + 1;
          gotBurst    = 0;
        end
        if (dataValidOut) begin
          if (expWords.size() == 0) begin
            errors++;
            $display("Unexpected data word %0h written at %0t", addressDataOut, $time);
          end else begin
            assert (addressDataOut == expWords[0]) else begin
              errors++;
              $display("Mismatch at %0t: data %0h, expected %0h", $time,
                       addressDataOut, expWords[0]);
            end
            lastLine = expLines[0];
            void'(expWords.pop_front());
            void'(expLines.pop_front());
          end
          wordsChecked++;
          frameWritten++;
          gotBurst++;
        end
        if (endTransactionOut) begin
          burstOpen = 1'b0;
          if (errInBurst) begin
            errInBurst = 1'b0;
            while (expLines.size() > 0 && expLines[0] == lastLine) begin
              void'(expWords.pop_front());
              void'(expLines.pop_front());
            end
          end else begin
            assert (gotBurst == expectBurst) else begin
              errors++;
              $display("Mismatch at %0t: burst carried %0d words, expected %0d", $time,
                       gotBurst, expectBurst);
            end
          end
        end
      end
      prevAddr  = addressDataOut;
      prevValid = dataValidOut;
      prevBegin = beginTransactionOut;
      prevEnd   = endTransactionOut;
      prevSize  = burstSizeOut;
      prevBe    = byteEnablesOut;

      // a pending request stays up until it is granted
      assert (!(prevRequest && !busGrant) || requestBus) else begin
        errors++;
        $display("requestBus dropped at %0t before the bus was granted", $time);
      end
      prevRequest = requestBus;

      // grant after a short random wait
      if (requestBus && !busGrant) begin
        if (grantWait == 0) begin
          busGrant  = 1'b1;
          grantWait = $unsigned($random(seed)) % 4;
        end else begin
          grantWait--;
        end
      end else begin
        busGrant = 1'b0;
      end
      busErrorIn = 1'b0;
      if (burstOpen && !errUsed && wordsChecked == errWordIdx) begin
        busErrorIn = 1'b1;
        errUsed    = 1'b1;
        errInBurst = 1'b1;
      end
      busyIn  = (($random(seed) & 3) == 0) && (busyRun < 2);
      busyRun = busyIn ? busyRun + 1 : 0;
    end
  end

  initial begin
    #((framesSent * frameCycles * 3 + 10) * 20);
    $display("Timeout: the run did not finish in time");
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    @(posedge rstN);
    @(negedge pclk);
    assert (!requestBus && !beginTransactionOut && !endTransactionOut && !dataValidOut &&
            byteEnablesOut == 4'h0 && burstSizeOut == 8'd0 && !ciDone) else begin
      errors++;
      $display("Mismatch at %0t: outputs not idle after reset", $time);
    end
    ciAccess(4'd5, baseAddr | 32'h3, readValue);
    checkRead(4'd4, baseAddr);
    ciAccess(4'd6, 32'd1, readValue);
    sendFrame(1'b1);
    sendFrame(1'b1);
    // single shot, which also stops continuous mode
    ciAccess(4'd6, 32'd2, readValue);
    sendFrame(1'b1);
    checkRead(4'd7, 32'd0);
    sendFrame(1'b0);
    vsyncPulse();
    repeat (20) @(negedge pclk);
    checkRead(4'd0, 32'd96);
    otherCiAccess(8'd1);
    checkRead(4'd1, 32'd4);
    checkRead(4'd2, 32'd0);
    checkRead(4'd3, 32'd0);
    checkRead(4'd7, 32'd1);
    ciAccess(4'd6, 32'd2, readValue);
    checkRead(4'd7, 32'd0);
    assert (expWords.size() == 0) else begin
      errors++;
      $display("%0d expected words were never written", expWords.size());
    end
    assert (errUsed) else begin
      errors++;
      $display("The bus error was never raised during a burst");
    end
    $display("Checks done: %0d errors, %0d bus words checked", errors, wordsChecked);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: verification/grabber_sva.sv
`timescale 1ns/1ps

module grabber_sva (
  input logic        pclk,
  input logic        rstN,
  input logic        ciDone,
  input logic [31:0] ciResult,
  input logic        beginTransactionOut,
  input logic        endTransactionOut,
  input logic        dataValidOut,
  input logic [3:0]  byteEnablesOut,
  input logic [7:0]  burstSizeOut,
  input logic [31:0] addressDataOut,
  input logic        busyIn,
  input logic        busErrorIn,
  input logic        lineDone
);

  logic burstOpen;
  logic errPending;
  logic inBurst;

  // burst runs from the begin cycle until end shows up
  assign inBurst = (beginTransactionOut || burstOpen) && !endTransactionOut;

  always_ff @(posedge pclk) begin
    if (!rstN) begin
      burstOpen  <= 1'b0;
      errPending <= 1'b0;
    end else begin
      if (endTransactionOut) begin
        burstOpen <= 1'b0;
      end else if (beginTransactionOut) begin
        burstOpen <= 1'b1;
      end
      // line is abandoned until the next line end
      if (inBurst && busErrorIn) begin
        errPending <= 1'b1;
      end else if (lineDone) begin
        errPending <= 1'b0;
      end
    end
  end

  resultZero: assert property (@(posedge pclk) disable iff (!rstN)
    !ciDone |-> (ciResult == 32'd0))
    else $error("ciResult not zero without ciDone");

  burstHeader: assert property (@(posedge pclk) disable iff (!rstN)
    beginTransactionOut |-> (burstSizeOut <= 8'd15) && (byteEnablesOut == 4'hF))
    else $error("bad burst header");

  errorEnds: assert property (@(posedge pclk) disable iff (!rstN)
    (inBurst && busErrorIn) |=> endTransactionOut)
    else $error("bus error not followed by end of transaction");

  busyHolds: assert property (@(posedge pclk) disable iff (!rstN)
    (inBurst && busyIn && !busErrorIn) |=> ($stable(addressDataOut) &&
      $stable(dataValidOut) && $stable(beginTransactionOut)))
    else $error("bus outputs moved while busy");

  quietAfterError: assert property (@(posedge pclk) disable iff (!rstN)
    errPending |-> !dataValidOut)
    else $error("data written after a bus error");

endmodule
